//--- all.f
+incdir+src
src/mb_pkg.sv
src/mb_alloc.sv
src/mb_cam.sv
src/mb_top.sv
test/tb_mb_top.sv

//--- run.sh
#!/bin/sh
# build and run the miss buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/100ps \
  --top-module tb_mb_top \
  -f all.f \
  -o sim_mb

./obj_dir/sim_mb > sim.log 2>&1
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  exit 0
else
  exit 1
fi

//--- src/mb_alloc.sv
`timescale 1ns/100ps
`default_nettype none

module mb_alloc (
  input  logic           rclk,
  input  logic           rst_l,
  input  logic           insert_en,
  input  logic           retire_en,
  input  mb_pkg::mb_wl_t retire_wl,
  output logic           alloc_we,
  output mb_pkg::mb_wl_t alloc_wl,
  output mb_pkg::mb_wl_t valid,
  output logic           full,
  output logic           insert_drop
);

  import mb_pkg::*;

  mb_wl_t free;
  mb_wl_t pick;
  mb_wl_t retire_mask;
  mb_wl_t valid_nxt;
  logic   grant;

  //////////////////////////////
  // free entry pick
  //////////////////////////////

  assign free = ~valid;

  // isolate the lowest set bit of the free vector
  assign pick = free & (~free + 1'b1);

  // no free bit left
  assign full = &valid;

  // insert only sees entries free before this edge
  assign grant = insert_en && !full;

  //////////////////////////////
  // valid vector
  //////////////////////////////

  assign retire_mask = retire_en ? retire_wl : '0;

  // retire clears first, then the granted bit is set
  always_comb begin
    valid_nxt = valid & ~retire_mask;
    if (grant) begin
      valid_nxt = valid_nxt | pick;
    end
  end

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      valid <= '0;
    end else begin
      valid <= valid_nxt;
    end
  end

  //////////////////////////////
  // grant and drop flags
  //////////////////////////////

  // wordline holds the last grant
  // write strobe and drop are one cycle pulses
  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      alloc_we    <= 1'b0;
      alloc_wl    <= '0;
      insert_drop <= 1'b0;
    end else begin
      alloc_we    <= grant;
      insert_drop <= insert_en && full;
      if (grant) begin
        alloc_wl <= pick;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/mb_cam.sv
`timescale 1ns/100ps
`default_nettype none

`include "mb_config.svh"

module mb_cam (
  input  logic              rclk,
  input  logic              rst_l,
  // write port from the allocator
  input  logic              alloc_we,
  input  mb_pkg::mb_wl_t    alloc_wl,
  input  mb_pkg::mb_entry_t wr_data,
  // entry valid bits qualify every compare
  input  mb_pkg::mb_wl_t    valid,
  // compare port
  input  logic              lookup_en,
  input  mb_pkg::mb_key_t   lookup_key,
  // read port
  input  logic              rd_en,
  input  mb_pkg::mb_wl_t    rd_wl,
  output mb_pkg::mb_match_t lookup_res,
  output mb_pkg::mb_entry_t rd_data
);

  import mb_pkg::*;

  // the array itself
  mb_entry_t mem [`MB_ENTRIES];

  // write stage
  logic      wr_en_q;
  mb_wl_t    wr_wl_q;
  mb_entry_t wr_data_q;

  // lookup stage
  logic      lookup_en_q;
  mb_key_t   key_q;
  mb_match_t match_nxt;

  // read stage
  logic      rd_en_q;
  mb_wl_t    rd_wl_q;
  mb_entry_t rd_mux;

  // true when exactly one bit is set
  function automatic logic wl_onehot(input mb_wl_t wl);
    return (wl != '0) && ((wl & (wl - 1'b1)) == '0);
  endfunction

  //////////////////////////////
  // write port
  //////////////////////////////

  // strobe, wordline and data are flopped together
  // array is written on the following edge
  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= alloc_we;
    end
  end

  always_ff @(posedge rclk) begin
    wr_wl_q   <= alloc_wl;
    wr_data_q <= wr_data;
  end

  // a wordline that is not one-hot writes nothing
  always_ff @(posedge rclk) begin
    if (wr_en_q && wl_onehot(wr_wl_q)) begin
      for (int i = 0; i < `MB_ENTRIES; i++) begin
        if (wr_wl_q[i]) begin
          mem[i] <= wr_data_q;
        end
      end
    end
  end

  //////////////////////////////
  // compare port
  //////////////////////////////

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      lookup_en_q <= 1'b0;
    end else begin
      lookup_en_q <= lookup_en;
    end
  end

  always_ff @(posedge rclk) begin
    key_q <= lookup_key;
  end

  // every entry compared in parallel
  // free entries never hit even if stale data is still there
  always_comb begin
    match_nxt = '0;
    for (int i = 0; i < `MB_ENTRIES; i++) begin
      match_nxt.hit[i]     = valid[i] &&
                             (mem[i][`MB_WIDTH-1:`MB_KEY_LSB] == key_q);
      match_nxt.idx_hit[i] = valid[i] &&
                             (mem[i][`MB_IDX_MSB:`MB_KEY_LSB] ==
                              key_q[`MB_IDX_MSB:`MB_KEY_LSB]);
    end
  end

  // result is zero for a cycle without a request
  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      lookup_res <= '0;
    end else begin
      lookup_res <= lookup_en_q ? match_nxt : '0;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
  end

  always_ff @(posedge rclk) begin
    rd_wl_q <= rd_wl;
  end

  // and-or mux over the wordline
  // no valid wordline selected reads as all ones like the sense amps
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i < `MB_ENTRIES; i++) begin
      if (rd_wl_q[i]) begin
        rd_mux = rd_mux | mem[i];
      end
    end
    if (!wl_onehot(rd_wl_q)) begin
      rd_mux = '1;
    end
  end

  // mem still holds the pre-write contents at this edge
  // so a read that meets a write returns the old entry
  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      rd_data <= '0;
    end else if (rd_en_q) begin
      rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- src/mb_config.svh
`ifndef MB_CONFIG_SVH
`define MB_CONFIG_SVH

// miss buffer geometry

// outstanding miss entries
`define MB_ENTRIES 16

// stored physical address width
`define MB_WIDTH 40

// lowest address bit that takes part in compares
`define MB_KEY_LSB 8

// top bit of the set index compare
`define MB_IDX_MSB 17

`endif

//--- src/mb_pkg.sv
`default_nettype none

`include "mb_config.svh"

package mb_pkg;

  //////////////////////////////
  // vector types
  //////////////////////////////

  // one stored miss address
  typedef logic [`MB_WIDTH-1:0] mb_entry_t;

  // lookup key keeps the original address bit numbering
  typedef logic [`MB_WIDTH-1:`MB_KEY_LSB] mb_key_t;

  // one bit per entry
  // used for wordlines, valid bits and match vectors
  typedef logic [`MB_ENTRIES-1:0] mb_wl_t;

  //////////////////////////////
  // lookup result
  //////////////////////////////

  // hit is a full key match, idx_hit matches the set index only
  typedef struct packed {
    mb_wl_t hit;
    mb_wl_t idx_hit;
  } mb_match_t;

endpackage

`default_nettype wire

//--- src/mb_top.sv
`timescale 1ns/100ps
`default_nettype none

module mb_top (
  input  logic              rclk,
  input  logic              rst_l,
  // insert side
  input  logic              insert_en,
  input  mb_pkg::mb_entry_t insert_addr,
  output mb_pkg::mb_wl_t    insert_wl,
  output logic              insert_drop,
  output logic              full,
  // lookup side
  input  logic              lookup_en,
  input  mb_pkg::mb_key_t   lookup_key,
  output mb_pkg::mb_match_t lookup_res,
  // read side
  input  logic              rd_en,
  input  mb_pkg::mb_wl_t    rd_wl,
  output mb_pkg::mb_entry_t rd_data,
  // retire side
  input  logic              retire_en,
  input  mb_pkg::mb_wl_t    retire_wl
);

  import mb_pkg::*;

  logic      alloc_we;
  mb_wl_t    alloc_wl;
  mb_wl_t    valid;
  mb_entry_t wr_data;

  // insert address flop
  // the allocator needs an edge to grant, so the data waits one
  // edge here and reaches the array together with alloc_we
  always_ff @(posedge rclk) begin
    wr_data <= insert_addr;
  end

  assign insert_wl = alloc_wl;

  mb_alloc u_alloc (
    .rclk        (rclk),
    .rst_l       (rst_l),
    .insert_en   (insert_en),
    .retire_en   (retire_en),
    .retire_wl   (retire_wl),
    .alloc_we    (alloc_we),
    .alloc_wl    (alloc_wl),
    .valid       (valid),
    .full        (full),
    .insert_drop (insert_drop)
  );

  mb_cam u_cam (
    .rclk       (rclk),
    .rst_l      (rst_l),
    .alloc_we   (alloc_we),
    .alloc_wl   (alloc_wl),
    .wr_data    (wr_data),
    .valid      (valid),
    .lookup_en  (lookup_en),
    .lookup_key (lookup_key),
    .rd_en      (rd_en),
    .rd_wl      (rd_wl),
    .lookup_res (lookup_res),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

//--- test/tb_mb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mb_config.svh"

module tb_mb_top;

  import mb_pkg::*;

  logic      rclk;
  logic      rst_l;
  logic      insert_en;
  mb_entry_t insert_addr;
  mb_wl_t    insert_wl;
  logic      insert_drop;
  logic      full;
  logic      lookup_en;
  mb_key_t   lookup_key;
  mb_match_t lookup_res;
  logic      rd_en;
  mb_wl_t    rd_wl;
  mb_entry_t rd_data;
  logic      retire_en;
  mb_wl_t    retire_wl;

  // reference model, array contents and valid bits
  mb_entry_t   model_mem [`MB_ENTRIES];
  mb_wl_t      model_valid;

  int          errors;
  int          checks;
  int          addr_n;
  int unsigned seed_val;

  mb_top UUT (
    .rclk        (rclk),
    .rst_l       (rst_l),
    .insert_en   (insert_en),
    .insert_addr (insert_addr),
    .insert_wl   (insert_wl),
    .insert_drop (insert_drop),
    .full        (full),
    .lookup_en   (lookup_en),
    .lookup_key  (lookup_key),
    .lookup_res  (lookup_res),
    .rd_en       (rd_en),
    .rd_wl       (rd_wl),
    .rd_data     (rd_data),
    .retire_en   (retire_en),
    .retire_wl   (retire_wl)
  );

  // 100 ns clock
  initial begin
    rclk = 1'b0;
    forever #50 rclk = ~rclk;
  end

  //////////////////////////////
  // model helpers
  //////////////////////////////

  // lowest free entry as one-hot, zero when every entry is taken
  function automatic mb_wl_t model_pick();
    mb_wl_t wl;
    wl = '0;
    for (int i = `MB_ENTRIES - 1; i >= 0; i--) begin
      if (!model_valid[i]) begin
        wl = mb_wl_t'(1) << i;
      end
    end
    return wl;
  endfunction

  // random address with a set index unique to n
  // index 0x3ff is never handed out
  function automatic mb_entry_t make_addr(input int n);
    mb_entry_t   a;
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $urandom;
    lo = $urandom;
    a = {hi[7:0], lo};
    a[`MB_IDX_MSB:`MB_KEY_LSB] = 10'(n * 3 + 1);
    return a;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_entry(input string name, input mb_entry_t exp,
                             input mb_entry_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_wl(input string name, input mb_wl_t exp, input mb_wl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_match(input string name, input mb_match_t exp,
                             input mb_match_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected hit %h idx_hit %h actual hit %h idx_hit %h",
               $time, name, exp.hit, exp.idx_hit, act.hit, act.idx_hit);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // closing line and verdict
  task automatic finish_run();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // poll full on falling edges
  task automatic wait_full(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge rclk);
    while (full !== level && n < limit) begin
      @(negedge rclk);
      n++;
    end
    if (full !== level) begin
      errors++;
      $display("timeout: full did not go to %0b within %0d cycles", level, limit);
      finish_run();
    end
  endtask

  //////////////////////////////
  // bus operations
  //////////////////////////////

  // grant and drop are seen one edge after the insert is sampled
  task automatic do_insert(input mb_entry_t addr);
    mb_wl_t pick;
    logic   drop;
    pick = model_pick();
    drop = (pick == '0);
    @(posedge rclk);
    insert_en   <= 1'b1;
    insert_addr <= addr;
    @(posedge rclk);
    insert_en <= 1'b0;
    for (int i = 0; i < `MB_ENTRIES; i++) begin
      if (pick[i]) begin
        model_mem[i] = addr;
      end
    end
    model_valid = model_valid | pick;
    @(negedge rclk);
    check_flag("insert_drop", drop, insert_drop);
    if (!drop) begin
      check_wl("insert_wl", pick, insert_wl);
    end
    check_flag("full", &model_valid, full);
  endtask

  // data is back two edges after rd_en is sampled
  task automatic do_read(input mb_wl_t wl, input mb_entry_t exp);
    @(posedge rclk);
    rd_en <= 1'b1;
    rd_wl <= wl;
    @(posedge rclk);
    rd_en <= 1'b0;
    @(posedge rclk);
    @(negedge rclk);
    check_entry("rd_data", exp, rd_data);
  endtask

  // zero after one edge, the result after two
  task automatic do_lookup(input mb_key_t key, input mb_match_t exp);
    @(posedge rclk);
    lookup_en  <= 1'b1;
    lookup_key <= key;
    @(posedge rclk);
    lookup_en <= 1'b0;
    @(negedge rclk);
    check_match("lookup_res one edge early", '0, lookup_res);
    @(negedge rclk);
    check_match("lookup_res", exp, lookup_res);
  endtask

  task automatic do_retire(input mb_wl_t wl);
    @(posedge rclk);
    retire_en <= 1'b1;
    retire_wl <= wl;
    @(posedge rclk);
    retire_en <= 1'b0;
    model_valid = model_valid & ~wl;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge rclk);
    check_flag("full", 1'b0, full);
    check_flag("insert_drop", 1'b0, insert_drop);
    check_match("lookup_res", '0, lookup_res);
    check_entry("rd_data", '0, rd_data);
    // entries are handed out from bit 0 upward
    for (int i = 0; i < 4; i++) begin
      do_insert(make_addr(addr_n));
      addr_n++;
      check_wl("insert_wl", mb_wl_t'(1) << i, insert_wl);
    end
  endtask

  task automatic test_read_back();
    for (int i = 0; i < 4; i++) begin
      do_read(mb_wl_t'(1) << i, model_mem[i]);
    end
    // no wordline and two wordlines both read all ones
    do_read('0, '1);
    do_read(mb_wl_t'(3), '1);
  endtask

  task automatic test_lookup();
    mb_key_t   key;
    mb_match_t exp;
    key = model_mem[2][`MB_WIDTH-1:`MB_KEY_LSB];
    exp.hit     = mb_wl_t'(1) << 2;
    exp.idx_hit = mb_wl_t'(1) << 2;
    do_lookup(key, exp);
    // top bit differs, set index still matches
    key[`MB_WIDTH-1] = ~key[`MB_WIDTH-1];
    exp.hit = '0;
    do_lookup(key, exp);
    key[`MB_IDX_MSB:`MB_KEY_LSB] = '1;
    do_lookup(key, '0);
  endtask

  task automatic test_fill();
    mb_entry_t dropped;
    while (model_pick() != '0) begin
      do_insert(make_addr(addr_n));
      addr_n++;
    end
    wait_full(1'b1, 4);
    dropped = make_addr(addr_n);
    addr_n++;
    do_insert(dropped);
    // drop is a single cycle pulse
    @(negedge rclk);
    check_flag("insert_drop", 1'b0, insert_drop);
    for (int i = 0; i < `MB_ENTRIES; i++) begin
      do_read(mb_wl_t'(1) << i, model_mem[i]);
    end
    do_lookup(dropped[`MB_WIDTH-1:`MB_KEY_LSB], '0);
  endtask

  task automatic test_retire();
    mb_key_t key;
    key = model_mem[5][`MB_WIDTH-1:`MB_KEY_LSB];
    do_retire(mb_wl_t'(1) << 5);
    wait_full(1'b0, 4);
    do_lookup(key, '0);
    do_insert(make_addr(addr_n));
    addr_n++;
    check_wl("insert_wl", mb_wl_t'(1) << 5, insert_wl);
  endtask

  // array write lands three edges after the insert is driven
  task automatic test_read_during_write();
    mb_wl_t    wl;
    mb_entry_t old_val;
    mb_entry_t new_val;
    wl      = mb_wl_t'(1) << 9;
    old_val = model_mem[9];
    new_val = make_addr(addr_n);
    addr_n++;
    do_retire(wl);
    wait_full(1'b0, 4);
    @(posedge rclk);
    insert_en   <= 1'b1;
    insert_addr <= new_val;
    @(posedge rclk);
    insert_en <= 1'b0;
    rd_en     <= 1'b1;
    rd_wl     <= wl;
    model_valid = model_valid | wl;
    model_mem[9] = new_val;
    @(negedge rclk);
    check_wl("insert_wl", wl, insert_wl);
    // second read sampled on the write edge
    @(posedge rclk);
    @(posedge rclk);
    rd_en <= 1'b0;
    @(negedge rclk);
    check_entry("rd_data during write", old_val, rd_data);
    @(negedge rclk);
    check_entry("rd_data after write", new_val, rd_data);
  endtask

  initial begin
    seed_val = $urandom(1540);
    rst_l       <= 1'b0;
    insert_en   <= 1'b0;
    insert_addr <= '0;
    lookup_en   <= 1'b0;
    lookup_key  <= '0;
    rd_en       <= 1'b0;
    rd_wl       <= '0;
    retire_en   <= 1'b0;
    retire_wl   <= '0;
    errors      = 0;
    checks      = 0;
    addr_n      = 0;
    model_valid = '0;
    repeat (10) @(posedge rclk);
    rst_l <= 1'b1;
    test_reset_state();
    test_read_back();
    test_lookup();
    test_fill();
    test_retire();
    test_read_during_write();
    finish_run();
  end

endmodule

`default_nettype wire
